//--- compile.f
rob_pkg.sv
rob_issue_stage.sv
rob_buffer.sv
rob_commit_stage.sv
arch_reg_file.sv
rob_top.sv
tb_rob_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_rob_top -o sim_rob
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_rob)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

//--- tb_rob_top.sv
`timescale 1ns/1ps

module tb_rob_top;

  typedef struct packed {
    logic                  iv;
    rob_pkg::issue_req_t   rq;
    rob_pkg::result_bus_t  lsb;
    rob_pkg::result_bus_t  alu;
    logic                  chk_op;   // operands and issue_dest only checked on issue rows
    rob_pkg::operand_t     e1;
    rob_pkg::operand_t     e2;
    rob_pkg::rob_id_t      ed;
    rob_pkg::commit_t      ec;
    rob_pkg::rob_id_t      es;
    logic                  ef;
  } row_t;

  logic                  clk;
  logic                  is_any_reset;
  logic                  issue_valid;
  rob_pkg::issue_req_t   req;
  logic                  rob_full;
  rob_pkg::operand_t     op1;
  rob_pkg::operand_t     op2;
  rob_pkg::rob_id_t      issue_dest;
  rob_pkg::result_bus_t  lsb_bus;
  rob_pkg::result_bus_t  alu_bus;
  rob_pkg::commit_t      commit;
  rob_pkg::rob_id_t      store_commit_id;
  rob_pkg::flush_t       flush;

  row_t        rows[$];
  row_t        r;
  logic [31:0] v [8];
  int          test_errors;
  int          total_errors;
  int          tests_failed;
  int          tests_run;
  int          first;

  localparam logic [31:0] PC_OK   = 32'h0000_1040;
  localparam logic [31:0] PC_PRED = 32'h0000_2000;
  localparam logic [31:0] PC_REAL = 32'h0000_2c84;

  rob_top i_dut (
    .clk, .is_any_reset, .issue_valid, .req, .rob_full, .op1, .op2, .issue_dest,
    .lsb_bus, .alu_bus, .commit, .store_commit_id, .flush
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit
  initial begin
    for (int i = 0; i < 5000; i++) begin
      @(posedge clk);
    end
    $display("timeout: simulation did not reach the end");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic rob_pkg::issue_req_t ireq(input rob_pkg::entry_kind_e kind,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
      input logic [31:0] pc);
    rob_pkg::issue_req_t q;
    q.kind    = kind;
    q.rd      = rd;
    q.rs1     = rs1;
    q.rs2     = rs2;
    q.pred_pc = pc;
    return q;
  endfunction

  function automatic rob_pkg::result_bus_t bus(input rob_pkg::rob_id_t dest,
      input logic [31:0] value, input logic [31:0] pc);
    rob_pkg::result_bus_t b;
    b.dest    = dest;
    b.value   = value;
    b.next_pc = pc;
    return b;
  endfunction

  function automatic rob_pkg::operand_t opnd(input logic ready, input logic [31:0] value,
      input rob_pkg::rob_id_t tag);
    rob_pkg::operand_t o;
    o.ready = ready;
    o.value = value;
    o.tag   = tag;
    return o;
  endfunction

  function automatic rob_pkg::commit_t cmt(input rob_pkg::rob_id_t dest,
      input logic [4:0] rd, input logic [31:0] value);
    rob_pkg::commit_t c;
    c.valid = 1'b1;
    c.dest  = dest;
    c.rd    = rd;
    c.value = value;
    return c;
  endfunction

  function automatic row_t idle_row();
    row_t x;
    x = '0;
    return x;
  endfunction

  function automatic row_t issue_row(input rob_pkg::issue_req_t rq,
      input rob_pkg::operand_t e1, input rob_pkg::operand_t e2, input int dest);
    row_t x;
    x        = '0;
    x.iv     = 1'b1;
    x.rq     = rq;
    x.chk_op = 1'b1;
    x.e1     = e1;
    x.e2     = e2;
    x.ed     = rob_pkg::rob_id_t'(dest);
    return x;
  endfunction

  task automatic compare_operand(input string name, input rob_pkg::operand_t got,
      input rob_pkg::operand_t exp);
    // a pending operand carries no meaningful value
    if ((exp.ready && got !== exp) ||
        (!exp.ready && (got.ready !== 1'b0 || got.tag !== exp.tag))) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_commit(input string name, input rob_pkg::commit_t got,
      input rob_pkg::commit_t exp);
    if ((exp.valid && got !== exp) || (!exp.valid && got.valid !== 1'b0)) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_id(input string name, input rob_pkg::rob_id_t got,
      input rob_pkg::rob_id_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_flush(input string name, input rob_pkg::flush_t got,
      input rob_pkg::flush_t exp);
    if ((exp.valid && got !== exp) || (!exp.valid && got.valid !== 1'b0)) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic drive_idle();
    issue_valid = 1'b0;
    lsb_bus     = '0;
    alu_bus     = '0;
  endtask

  task automatic apply_row(input row_t x);
    @(posedge clk);
    #1;
    issue_valid = x.iv;
    req         = x.rq;
    lsb_bus     = x.lsb;
    alu_bus     = x.alu;
    #2;   // sample a cycle's outputs before the next edge
    if (x.chk_op) begin
      compare_operand("op1", op1, x.e1);
      compare_operand("op2", op2, x.e2);
      compare_id("issue_dest", issue_dest, x.ed);
    end
    compare_commit("commit", commit, x.ec);
    compare_id("store_commit_id", store_commit_id, x.es);
    compare_flush("flush", flush, '0);
    compare_bit("rob_full", rob_full, x.ef);
  endtask

  task automatic apply_rows(input int from, input int upto);
    for (int i = from; i < upto; i++) begin
      apply_row(rows[i]);
    end
  endtask

  task automatic wait_for_flush(input logic [31:0] pc);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 20 && !seen; i++) begin
      @(posedge clk);
      #1;
      drive_idle();
      #2;
      seen = flush.valid;
    end
    if (!seen) begin
      $display("flush did not rise within 20 cycles of the mispredicted branch");
      test_errors++;
    end else begin
      compare_flush("flush", flush, {1'b1, pc});
    end
  endtask

  task automatic wait_for_full();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 20 && !seen; i++) begin
      @(posedge clk);
      #1;
      drive_idle();
      #2;
      seen = rob_full;
    end
    if (!seen) begin
      $display("rob_full did not rise after eight issues");
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    void'($urandom(32'h3a5c_4051));
    for (int i = 0; i < 8; i++) begin
      v[i] = $urandom;
    end
    test_errors  = 0;
    total_errors = 0;
    tests_failed = 0;
    tests_run    = 0;
    is_any_reset = 1'b0;
    req          = '0;
    drive_idle();
    repeat (3) @(posedge clk);
    #1;
    is_any_reset = 1'b1;

    // reset state, then ids 1, 2, 3
    first = rows.size();
    rows.push_back(idle_row());
    rows.push_back(issue_row(ireq(rob_pkg::KIND_NORMAL, 1, 0, 0, 0),
                             opnd(1, 0, 0), opnd(1, 0, 0), 1));
    rows.push_back(issue_row(ireq(rob_pkg::KIND_NORMAL, 2, 1, 0, 0),
                             opnd(0, 0, 1), opnd(1, 0, 0), 2));
    r = issue_row(ireq(rob_pkg::KIND_NORMAL, 3, 2, 1, 0),
                  opnd(1, v[1], 0), opnd(0, 0, 1), 3);
    r.lsb = bus(2, v[1], 0);   // same-cycle forward for rs1
    rows.push_back(r);
    apply_rows(first, rows.size());
    end_test("reset and issue ids");

    // out of order completion, in order commit
    first = rows.size();
    r = issue_row(ireq(rob_pkg::KIND_NORMAL, 0, 2, 3, 0),
                  opnd(1, v[1], 0), opnd(1, v[2], 0), 4);
    r.alu = bus(3, v[2], 0);
    rows.push_back(r);
    rows.push_back(idle_row());
    r = idle_row();
    r.lsb = bus(1, v[0], 0);
    rows.push_back(r);
    rows.push_back(idle_row());
    r = idle_row();
    r.ec = cmt(1, 1, v[0]);
    rows.push_back(r);
    r = issue_row(ireq(rob_pkg::KIND_STORE, 0, 1, 0, 0), opnd(1, v[0], 0), opnd(1, 0, 0), 5);
    r.ec = cmt(2, 2, v[1]);
    rows.push_back(r);
    r = idle_row();
    r.ec = cmt(3, 3, v[2]);
    rows.push_back(r);
    r = idle_row();
    r.alu = bus(4, v[3], 0);
    rows.push_back(r);
    rows.push_back(idle_row());
    r = idle_row();
    r.ec = cmt(4, 0, v[3]);
    rows.push_back(r);
    apply_rows(first, rows.size());
    end_test("ordering and operand forwarding");

    first = rows.size();
    r = idle_row();
    r.es = 5;
    rows.push_back(r);
    rows.push_back(idle_row());
    apply_rows(first, rows.size());
    end_test("store retire");

    // branch ok, then a mispredict with younger work behind it
    first = rows.size();
    rows.push_back(issue_row(ireq(rob_pkg::KIND_BRANCH, 0, 0, 0, PC_OK),
                             opnd(1, 0, 0), opnd(1, 0, 0), 6));
    r = idle_row();
    r.alu = bus(6, 0, PC_OK);
    rows.push_back(r);
    rows.push_back(idle_row());
    r = idle_row();
    r.ec = cmt(6, 0, 0);
    rows.push_back(r);
    rows.push_back(issue_row(ireq(rob_pkg::KIND_BRANCH, 0, 0, 0, PC_PRED),
                             opnd(1, 0, 0), opnd(1, 0, 0), 7));
    rows.push_back(issue_row(ireq(rob_pkg::KIND_NORMAL, 6, 0, 0, 0),
                             opnd(1, 0, 0), opnd(1, 0, 0), 8));
    r = issue_row(ireq(rob_pkg::KIND_NORMAL, 7, 0, 0, 0), opnd(1, 0, 0), opnd(1, 0, 0), 1);
    r.alu = bus(7, 0, PC_REAL);
    r.lsb = bus(8, v[4], 0);
    rows.push_back(r);
    apply_rows(first, rows.size());
    wait_for_flush(PC_REAL);
    first = rows.size();
    rows.push_back(issue_row(ireq(rob_pkg::KIND_NORMAL, 8, 6, 0, 0),
                             opnd(1, 0, 0), opnd(1, 0, 0), 1));
    r = idle_row();
    r.lsb = bus(1, v[5], 0);
    rows.push_back(r);
    rows.push_back(idle_row());
    r = idle_row();
    r.ec = cmt(1, 8, v[5]);
    rows.push_back(r);
    apply_rows(first, rows.size());
    end_test("branch commit and flush");

    // fill all eight entries, head sits at 2
    first = rows.size();
    for (int i = 0; i < 8; i++) begin
      rows.push_back(issue_row(ireq(rob_pkg::KIND_NORMAL, 0, 0, 0, 0),
                               opnd(1, 0, 0), opnd(1, 0, 0), ((1 + i) % 8) + 1));
    end
    apply_rows(first, rows.size());
    wait_for_full();
    first = rows.size();
    r = issue_row(ireq(rob_pkg::KIND_NORMAL, 9, 0, 0, 0), opnd(1, 0, 0), opnd(1, 0, 0), 2);
    r.ef = 1'b1;
    rows.push_back(r);
    r = idle_row();
    r.lsb = bus(2, v[6], 0);
    r.ef  = 1'b1;
    rows.push_back(r);
    r = idle_row();
    r.ef = 1'b1;
    rows.push_back(r);
    r = idle_row();
    r.ec = cmt(2, 0, v[6]);
    rows.push_back(r);
    // x8 producer retired and its slot reused by a pending entry
    rows.push_back(issue_row(ireq(rob_pkg::KIND_NORMAL, 0, 9, 8, 0),
                             opnd(1, 0, 0), opnd(1, v[5], 0), 2));
    apply_rows(first, rows.size());
    end_test("full buffer");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- rob_top.sv
`timescale 1ns/1ps

module rob_top (
  input  logic                   clk,
  input  logic                   is_any_reset,
  input  logic                   issue_valid,
  input  rob_pkg::issue_req_t    req,
  output logic                   rob_full,
  output rob_pkg::operand_t      op1,
  output rob_pkg::operand_t      op2,
  output rob_pkg::rob_id_t       issue_dest,
  input  rob_pkg::result_bus_t   lsb_bus,
  input  rob_pkg::result_bus_t   alu_bus,
  output rob_pkg::commit_t       commit,
  output rob_pkg::rob_id_t       store_commit_id,
  output rob_pkg::flush_t        flush
);

  logic                          clear;
  logic                          alloc;
  logic                          retire;
  logic                          rename_we;
  logic [rob_pkg::REG_ID_W-1:0]  rename_rd;
  rob_pkg::rob_id_t              next_id;
  rob_pkg::rob_id_t              rs1_tag, rs2_tag;
  logic [rob_pkg::XLEN-1:0]      rs1_value, rs2_value;
  rob_pkg::rob_id_t              lookup1_id, lookup2_id;
  logic                          lookup1_done, lookup2_done;
  logic [rob_pkg::XLEN-1:0]      lookup1_value, lookup2_value;
  rob_pkg::head_view_t           head;

  assign clear = !is_any_reset || flush.valid;   // empties rob and tags

  rob_issue_stage i_issue (
    .clk, .issue_valid, .req, .rob_full, .lsb_bus, .alu_bus,
    .rs1_tag, .rs2_tag, .rs1_value, .rs2_value,
    .lookup1_id, .lookup2_id, .lookup1_done, .lookup2_done,
    .lookup1_value, .lookup2_value, .next_id, .alloc,
    .op1, .op2, .issue_dest, .rename_we, .rename_rd
  );

  rob_buffer i_buffer (
    .clk, .clear, .alloc, .req, .next_id, .rob_full,
    .lookup1_id, .lookup2_id, .lookup1_done, .lookup2_done,
    .lookup1_value, .lookup2_value, .lsb_bus, .alu_bus, .head, .retire
  );

  rob_commit_stage i_commit (
    .clk, .clear, .head, .retire, .commit, .store_commit_id, .flush
  );

  arch_reg_file i_regs (
    .clk, .is_any_reset, .clear_tags(clear),
    .rs1(req.rs1), .rs2(req.rs2), .rs1_tag, .rs2_tag, .rs1_value, .rs2_value,
    .rename_we, .rename_rd, .rename_tag(next_id), .commit
  );

endmodule

//--- arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file (
  input  logic                          clk,
  input  logic                          is_any_reset,
  input  logic                          clear_tags,
  input  logic [rob_pkg::REG_ID_W-1:0]  rs1,
  input  logic [rob_pkg::REG_ID_W-1:0]  rs2,
  output rob_pkg::rob_id_t              rs1_tag,
  output rob_pkg::rob_id_t              rs2_tag,
  output logic [rob_pkg::XLEN-1:0]      rs1_value,
  output logic [rob_pkg::XLEN-1:0]      rs2_value,
  input  logic                          rename_we,
  input  logic [rob_pkg::REG_ID_W-1:0]  rename_rd,
  input  rob_pkg::rob_id_t              rename_tag,
  input  rob_pkg::commit_t              commit
);

  logic [rob_pkg::XLEN-1:0] regs_q [rob_pkg::NUM_REGS];
  rob_pkg::rob_id_t         tags_q [rob_pkg::NUM_REGS];

  logic commit_we;

  assign commit_we = commit.valid && (commit.rd != '0);

  always_ff @(posedge clk) begin
    if (!is_any_reset) begin
      for (int i = 0; i < rob_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (commit_we) begin
      regs_q[commit.rd] <= commit.value;
    end
  end

  always_ff @(posedge clk) begin
    if (clear_tags) begin
      for (int i = 0; i < rob_pkg::NUM_REGS; i++) begin
        tags_q[i] <= '0;
      end
    end else begin
      // only the youngest producer's commit frees the tag
      if (commit_we && (tags_q[commit.rd] == commit.dest)) begin
        tags_q[commit.rd] <= '0;
      end
      if (rename_we) begin
        tags_q[rename_rd] <= rename_tag;   // rename wins over the clear
      end
    end
  end

  // x0 hardwired
  assign rs1_value = (rs1 == '0) ? '0 : regs_q[rs1];
  assign rs2_value = (rs2 == '0) ? '0 : regs_q[rs2];
  assign rs1_tag   = (rs1 == '0) ? '0 : tags_q[rs1];
  assign rs2_tag   = (rs2 == '0) ? '0 : tags_q[rs2];

endmodule

//--- rob_commit_stage.sv
`timescale 1ns/1ps

module rob_commit_stage (
  input  logic                    clk,
  input  logic                    clear,
  input  rob_pkg::head_view_t     head,
  output logic                    retire,
  output rob_pkg::commit_t        commit,
  output rob_pkg::rob_id_t        store_commit_id,
  output rob_pkg::flush_t         flush
);

  logic is_store;
  logic is_branch;
  logic mispredict;

  logic                          commit_valid_q;
  rob_pkg::rob_id_t              commit_dest_q;
  logic [rob_pkg::REG_ID_W-1:0]  commit_rd_q;
  logic [rob_pkg::XLEN-1:0]      commit_value_q;
  rob_pkg::rob_id_t              store_id_q;
  logic                          flush_valid_q;
  logic [rob_pkg::XLEN-1:0]      flush_pc_q;

  assign is_store   = (head.kind == rob_pkg::KIND_STORE);
  assign is_branch  = (head.kind == rob_pkg::KIND_BRANCH);
  assign mispredict = is_branch && (head.actual_pc != head.pred_pc);

  // stores need no completion
  assign retire = (head.kind != rob_pkg::KIND_NONE) && (head.done || is_store);

  always_ff @(posedge clk) begin
    if (clear) begin
      commit_valid_q <= 1'b0;
      store_id_q     <= '0;
      flush_valid_q  <= 1'b0;   // drops one cycle after it rose
    end else begin
      commit_valid_q <= retire && !is_store;
      store_id_q     <= (retire && is_store) ? head.id : '0;
      flush_valid_q  <= retire && mispredict;
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      commit_dest_q  <= head.id;
      commit_rd_q    <= head.rd;
      commit_value_q <= head.value;
    end
    if (retire && mispredict) begin
      flush_pc_q <= head.actual_pc;
    end
  end

  always_comb begin
    commit.valid = commit_valid_q;
    commit.dest  = commit_dest_q;
    commit.rd    = commit_rd_q;
    commit.value = commit_value_q;
    flush.valid  = flush_valid_q;
    flush.pc     = flush_pc_q;
  end

  assign store_commit_id = store_id_q;

endmodule

//--- rob_buffer.sv
`timescale 1ns/1ps

module rob_buffer (
  input  logic                      clk,
  input  logic                      clear,
  input  logic                      alloc,
  input  rob_pkg::issue_req_t       req,
  output rob_pkg::rob_id_t          next_id,
  output logic                      rob_full,
  input  rob_pkg::rob_id_t          lookup1_id,
  input  rob_pkg::rob_id_t          lookup2_id,
  output logic                      lookup1_done,
  output logic                      lookup2_done,
  output logic [rob_pkg::XLEN-1:0]  lookup1_value,
  output logic [rob_pkg::XLEN-1:0]  lookup2_value,
  input  rob_pkg::result_bus_t      lsb_bus,
  input  rob_pkg::result_bus_t      alu_bus,
  output rob_pkg::head_view_t       head,
  input  logic                      retire
);

  rob_pkg::rob_id_t               head_q;
  rob_pkg::rob_id_t               tail_q;   // next free slot
  logic [rob_pkg::ROB_ID_W-1:0]   count_q;

  rob_pkg::entry_kind_e           kind_q      [1:rob_pkg::ROB_DEPTH];
  logic                           done_q      [1:rob_pkg::ROB_DEPTH];
  logic [rob_pkg::REG_ID_W-1:0]   rd_q        [1:rob_pkg::ROB_DEPTH];
  logic [rob_pkg::XLEN-1:0]       value_q     [1:rob_pkg::ROB_DEPTH];
  logic [rob_pkg::XLEN-1:0]       pred_pc_q   [1:rob_pkg::ROB_DEPTH];
  logic [rob_pkg::XLEN-1:0]       actual_pc_q [1:rob_pkg::ROB_DEPTH];

  logic empty;

  // ids wrap 8 -> 1, never 0
  function automatic rob_pkg::rob_id_t wrap_inc(input rob_pkg::rob_id_t id);
    if (id == rob_pkg::rob_id_t'(rob_pkg::ROB_DEPTH)) begin
      return rob_pkg::rob_id_t'(1);
    end
    return id + rob_pkg::rob_id_t'(1);
  endfunction

  assign empty    = (count_q == '0);
  assign rob_full = (count_q == rob_pkg::ROB_ID_W'(rob_pkg::ROB_DEPTH));
  assign next_id  = tail_q;

  always_ff @(posedge clk) begin
    if (clear) begin
      head_q  <= rob_pkg::rob_id_t'(1);
      tail_q  <= rob_pkg::rob_id_t'(1);
      count_q <= '0;
    end else begin
      if (alloc) begin
        tail_q <= wrap_inc(tail_q);
      end
      if (retire) begin
        head_q <= wrap_inc(head_q);
      end
      case ({alloc, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // none, or one in and one out
      endcase
    end
  end

  // kind and done per entry
  always_ff @(posedge clk) begin
    if (clear) begin
      for (int i = 1; i <= rob_pkg::ROB_DEPTH; i++) begin
        kind_q[i] <= rob_pkg::KIND_NONE;
        done_q[i] <= 1'b0;
      end
    end else begin
      if (retire) begin
        kind_q[head_q] <= rob_pkg::KIND_NONE;   // done kept for late lookups
      end
      if (alloc) begin
        kind_q[tail_q] <= req.kind;
        done_q[tail_q] <= 1'b0;
      end
      if (lsb_bus.dest != '0) begin
        done_q[lsb_bus.dest] <= 1'b1;
      end
      if (alu_bus.dest != '0) begin
        done_q[alu_bus.dest] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      rd_q[tail_q]      <= req.rd;
      pred_pc_q[tail_q] <= req.pred_pc;
    end
    if (lsb_bus.dest != '0) begin
      value_q[lsb_bus.dest] <= lsb_bus.value;
    end
    if (alu_bus.dest != '0) begin
      value_q[alu_bus.dest]     <= alu_bus.value;
      actual_pc_q[alu_bus.dest] <= alu_bus.next_pc;
    end
  end

  assign lookup1_done  = (lookup1_id != '0) && done_q[lookup1_id];
  assign lookup2_done  = (lookup2_id != '0) && done_q[lookup2_id];
  assign lookup1_value = value_q[lookup1_id];
  assign lookup2_value = value_q[lookup2_id];

  always_comb begin
    head.id        = head_q;
    head.kind      = empty ? rob_pkg::KIND_NONE : kind_q[head_q];
    head.done      = done_q[head_q];
    head.rd        = rd_q[head_q];
    head.value     = value_q[head_q];
    head.pred_pc   = pred_pc_q[head_q];
    head.actual_pc = actual_pc_q[head_q];
  end

endmodule

//--- rob_issue_stage.sv
`timescale 1ns/1ps

module rob_issue_stage (
  input  logic                          clk,
  input  logic                          issue_valid,
  input  rob_pkg::issue_req_t           req,
  input  logic                          rob_full,
  input  rob_pkg::result_bus_t          lsb_bus,
  input  rob_pkg::result_bus_t          alu_bus,
  input  rob_pkg::rob_id_t              rs1_tag,
  input  rob_pkg::rob_id_t              rs2_tag,
  input  logic [rob_pkg::XLEN-1:0]      rs1_value,
  input  logic [rob_pkg::XLEN-1:0]      rs2_value,
  output rob_pkg::rob_id_t              lookup1_id,
  output rob_pkg::rob_id_t              lookup2_id,
  input  logic                          lookup1_done,
  input  logic                          lookup2_done,
  input  logic [rob_pkg::XLEN-1:0]      lookup1_value,
  input  logic [rob_pkg::XLEN-1:0]      lookup2_value,
  input  rob_pkg::rob_id_t              next_id,
  output logic                          alloc,
  output rob_pkg::operand_t             op1,
  output rob_pkg::operand_t             op2,
  output rob_pkg::rob_id_t              issue_dest,
  output logic                          rename_we,
  output logic [rob_pkg::REG_ID_W-1:0]  rename_rd
);

  // register file first, then a finished entry, then a bus in flight
  function automatic rob_pkg::operand_t resolve(
    input rob_pkg::rob_id_t          tag,
    input logic [rob_pkg::XLEN-1:0]  reg_value,
    input logic                      rob_done,
    input logic [rob_pkg::XLEN-1:0]  rob_value,
    input rob_pkg::result_bus_t      lsb,
    input rob_pkg::result_bus_t      alu
  );
    rob_pkg::operand_t op;
    op.ready = 1'b1;
    op.tag   = '0;
    op.value = reg_value;
    if (tag == '0) begin
      op.value = reg_value;
    end else if (rob_done) begin
      op.value = rob_value;
    end else if (lsb.dest == tag) begin
      op.value = lsb.value;
    end else if (alu.dest == tag) begin
      op.value = alu.value;
    end else begin
      op.ready = 1'b0;   // still pending, hand out the tag
      op.value = '0;
      op.tag   = tag;
    end
    return op;
  endfunction

  assign lookup1_id = rs1_tag;
  assign lookup2_id = rs2_tag;

  assign op1 = resolve(rs1_tag, rs1_value, lookup1_done, lookup1_value, lsb_bus, alu_bus);
  assign op2 = resolve(rs2_tag, rs2_value, lookup2_done, lookup2_value, lsb_bus, alu_bus);

  assign issue_dest = next_id;
  assign alloc      = issue_valid && !rob_full;

  // stores produce no register result
  assign rename_we = alloc && (req.rd != '0) && (req.kind != rob_pkg::KIND_STORE);
  assign rename_rd = req.rd;

endmodule

//--- rob_pkg.sv
package rob_pkg;

  localparam int ROB_DEPTH = 8;
  localparam int ROB_ID_W = 4;   // ids 1..8, 0 is "no entry"
  localparam int XLEN = 32;
  localparam int REG_ID_W = 5;
  localparam int NUM_REGS = 32;

  typedef logic [ROB_ID_W-1:0] rob_id_t;

  typedef enum logic [1:0] {
    KIND_NONE   = 2'd0,
    KIND_NORMAL = 2'd1,
    KIND_BRANCH = 2'd2,
    KIND_STORE  = 2'd3
  } entry_kind_e;

  typedef struct packed {
    entry_kind_e         kind;
    logic [REG_ID_W-1:0] rd;
    logic [REG_ID_W-1:0] rs1;
    logic [REG_ID_W-1:0] rs2;
    logic [XLEN-1:0]     pred_pc;   // predicted next pc, branches only
  } issue_req_t;

  typedef struct packed {
    logic            ready;
    logic [XLEN-1:0] value;
    rob_id_t         tag;
  } operand_t;

  typedef struct packed {
    rob_id_t         dest;      // 0 = bus idle
    logic [XLEN-1:0] value;
    logic [XLEN-1:0] next_pc;   // alu bus only
  } result_bus_t;

  typedef struct packed {
    rob_id_t             id;
    entry_kind_e         kind;
    logic                done;
    logic [REG_ID_W-1:0] rd;
    logic [XLEN-1:0]     value;
    logic [XLEN-1:0]     pred_pc;
    logic [XLEN-1:0]     actual_pc;
  } head_view_t;

  typedef struct packed {
    logic                valid;
    rob_id_t             dest;
    logic [REG_ID_W-1:0] rd;
    logic [XLEN-1:0]     value;
  } commit_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } flush_t;

endpackage
